// File: demosaic_pkg.sv
`default_nettype none

package demosaic_pkg;

    parameter int PIX_W = 8;
    parameter int SUM_W = PIX_W + 2; // four pixels summed

    typedef logic [PIX_W-1:0] pixel_t;

    // partner phases differ only in bit 0
    typedef enum logic [1:0] {
        PH_B_CENTER   = 2'd0,
        PH_G_RED_ROW  = 2'd1,
        PH_G_BLUE_ROW = 2'd2,
        PH_R_CENTER   = 2'd3
    } phase_t;

    typedef struct packed {
        logic col_last;
        logic pic_last;
    } marks_t;

    // p1 p2 p3 / p4 p5 p6 / p7 p8 p9
    typedef struct packed {
        pixel_t p1;
        pixel_t p2;
        pixel_t p3;
        pixel_t p4;
        pixel_t p5; // centre
        pixel_t p6;
        pixel_t p7;
        pixel_t p8;
        pixel_t p9; // newest pixel
    } window_t;

    typedef struct packed {
        window_t pix;
        phase_t  phase;
        marks_t  marks;
    } window_beat_t;

endpackage

`default_nettype wire

// File: stream_pkg.sv
`default_nettype none

package stream_pkg;

    typedef enum logic [1:0] {
        COLOR_R = 2'd0,
        COLOR_G = 2'd1,
        COLOR_B = 2'd2
    } color_t;

    typedef struct packed {
        demosaic_pkg::pixel_t r;
        demosaic_pkg::pixel_t g;
        demosaic_pkg::pixel_t b;
    } rgb_t;

    typedef struct packed {
        rgb_t                 rgb;
        demosaic_pkg::marks_t marks;
    } rgb_beat_t;

endpackage

`default_nettype wire

// File: column_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module column_buffer #(
    parameter int COL_HEIGHT = 8
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire                         valid,
    input  wire demosaic_pkg::pixel_t   data_in,
    input  wire                         end_col,
    input  wire                         end_pic,
    output logic                        win_valid,
    output demosaic_pkg::window_beat_t  win
);

    localparam int ROW_W = $clog2(COL_HEIGHT);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(COL_HEIGHT - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL1,
        ST_FILL2,
        ST_NEW_COL,
        ST_PATTERN
    } state_t;

    logic                   start_q;
    logic                   valid_q;
    logic                   end_col_q;
    logic                   end_pic_q;
    demosaic_pkg::pixel_t   data_q;

    state_t                 state_q;
    logic [ROW_W-1:0]       row_q;
    logic                   red_first_q;
    demosaic_pkg::phase_t   phase_q;

    demosaic_pkg::pixel_t   col_left  [COL_HEIGHT];
    demosaic_pkg::pixel_t   col_mid   [COL_HEIGHT];
    demosaic_pkg::pixel_t   col_right [COL_HEIGHT];

    logic [ROW_W-1:0]       row_up;
    logic [ROW_W-1:0]       row_ctr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q   <= 1'b0;
            valid_q   <= 1'b0;
            end_col_q <= 1'b0;
            end_pic_q <= 1'b0;
        end else begin
            start_q   <= start;
            valid_q   <= valid;
            end_col_q <= end_col;
            end_pic_q <= end_pic;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_in;
    end

    // position state machine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            row_q       <= '0;
            red_first_q <= 1'b1;
            phase_q     <= demosaic_pkg::PH_B_CENTER;
        end else if (state_q == ST_IDLE) begin
            if (start_q) begin
                state_q <= ST_FILL1;
            end
            row_q <= '0;
        end else if (valid_q) begin
            if (end_col_q) begin
                state_q <= ST_FILL1; // strip restarts
                row_q   <= '0;
            end else begin
                case (state_q)
                    ST_FILL1: begin
                        row_q <= (row_q == LAST_ROW) ? '0 : row_q + 1'b1;
                        if (row_q == LAST_ROW) begin
                            state_q <= ST_FILL2;
                        end
                    end
                    ST_FILL2: begin
                        row_q <= (row_q == LAST_ROW) ? '0 : row_q + 1'b1;
                        if (row_q == LAST_ROW) begin
                            state_q     <= ST_NEW_COL;
                            red_first_q <= 1'b1; // first pattern column is red-first
                        end
                    end
                    ST_NEW_COL: begin
                        row_q <= row_q + 1'b1;
                        if (row_q == ROW_W'(1)) begin
                            state_q <= ST_PATTERN;
                            phase_q <= red_first_q ? demosaic_pkg::PH_B_CENTER
                                                   : demosaic_pkg::PH_R_CENTER;
                        end
                    end
                    ST_PATTERN: begin
                        if (row_q == LAST_ROW) begin
                            state_q     <= ST_NEW_COL;
                            row_q       <= '0;
                            red_first_q <= ~red_first_q;
                        end else begin
                            row_q   <= row_q + 1'b1;
                            phase_q <= demosaic_pkg::phase_t'(phase_q ^ 2'b01);
                        end
                    end
                    default: state_q <= ST_IDLE;
                endcase
            end
        end
    end

    // column stores
    always_ff @(posedge clk) begin
        if (valid_q) begin
            case (state_q)
                ST_FILL1:   col_left[row_q]  <= data_q;
                ST_FILL2:   col_mid[row_q]   <= data_q;
                ST_NEW_COL: col_right[row_q] <= data_q;
                ST_PATTERN: begin
                    if (!end_col_q && row_q == LAST_ROW) begin
                        for (int i = 0; i < COL_HEIGHT; i++) begin
                            col_left[i] <= col_mid[i];
                            col_mid[i]  <= (i == COL_HEIGHT - 1) ? data_q : col_right[i];
                        end
                    end else begin
                        col_right[row_q] <= data_q;
                    end
                end
                default: ;
            endcase
        end
    end

    assign row_up  = row_q - ROW_W'(2);
    assign row_ctr = row_q - ROW_W'(1);

    always_comb begin
        win.pix.p1          = col_left[row_up];
        win.pix.p2          = col_mid[row_up];
        win.pix.p3          = col_right[row_up];
        win.pix.p4          = col_left[row_ctr];
        win.pix.p5          = col_mid[row_ctr];
        win.pix.p6          = col_right[row_ctr];
        win.pix.p7          = col_left[row_q];
        win.pix.p8          = col_mid[row_q];
        win.pix.p9          = data_q; // not yet stored
        win.phase           = phase_q;
        win.marks.col_last  = end_col_q;
        win.marks.pic_last  = end_pic_q;
    end

    assign win_valid = valid_q && (state_q == ST_PATTERN);

    // a window needs two rows above the new pixel
    a_row_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(row_q) < COL_HEIGHT && (state_q != ST_PATTERN || row_q >= ROW_W'(2)))
        else $error("row counter out of range");

endmodule

`default_nettype wire

// File: bayer_interp.sv
`timescale 1ns/10ps
`default_nettype none

module bayer_interp (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         win_valid,
    input  wire demosaic_pkg::window_beat_t win,
    output logic                        rgb_valid,
    output stream_pkg::rgb_beat_t       rgb
);

    typedef logic [demosaic_pkg::SUM_W-1:0] sum_t;

    logic                   s1_valid_q;
    sum_t                   up_sum_q;
    sum_t                   down_sum_q;
    sum_t                   hor_sum_q;
    sum_t                   ver_sum_q;
    demosaic_pkg::pixel_t   centre_q;
    demosaic_pkg::phase_t   phase_q;
    demosaic_pkg::marks_t   marks_q;

    sum_t                   corner_sum;
    sum_t                   cross_sum;
    stream_pkg::rgb_t       rgb_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
            rgb_valid  <= 1'b0;
        end else begin
            s1_valid_q <= win_valid;
            rgb_valid  <= s1_valid_q;
        end
    end

    // stage one neighbour sums
    always_ff @(posedge clk) begin
        if (win_valid) begin
            up_sum_q   <= sum_t'(win.pix.p1) + sum_t'(win.pix.p3);
            down_sum_q <= sum_t'(win.pix.p7) + sum_t'(win.pix.p9);
            hor_sum_q  <= sum_t'(win.pix.p4) + sum_t'(win.pix.p6);
            ver_sum_q  <= sum_t'(win.pix.p2) + sum_t'(win.pix.p8);
            centre_q   <= win.pix.p5;
            phase_q    <= win.phase;
            marks_q    <= win.marks;
        end
    end

    assign corner_sum = up_sum_q + down_sum_q;
    assign cross_sum  = hor_sum_q + ver_sum_q;

    always_comb begin
        case (phase_q)
            demosaic_pkg::PH_B_CENTER: begin
                rgb_d.r = demosaic_pkg::pixel_t'(corner_sum >> 2);
                rgb_d.g = demosaic_pkg::pixel_t'(cross_sum >> 2);
                rgb_d.b = centre_q;
            end
            demosaic_pkg::PH_G_RED_ROW: begin
                rgb_d.r = demosaic_pkg::pixel_t'(hor_sum_q >> 1);
                rgb_d.g = centre_q;
                rgb_d.b = demosaic_pkg::pixel_t'(ver_sum_q >> 1);
            end
            demosaic_pkg::PH_G_BLUE_ROW: begin
                rgb_d.r = demosaic_pkg::pixel_t'(ver_sum_q >> 1);
                rgb_d.g = centre_q;
                rgb_d.b = demosaic_pkg::pixel_t'(hor_sum_q >> 1);
            end
            default: begin // red centre
                rgb_d.r = centre_q;
                rgb_d.g = demosaic_pkg::pixel_t'(cross_sum >> 2);
                rgb_d.b = demosaic_pkg::pixel_t'(corner_sum >> 2);
            end
        endcase
    end

    // stage two finished triple
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            rgb.rgb   <= rgb_d;
            rgb.marks <= marks_q;
        end
    end

endmodule

`default_nettype wire

// File: rgb_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module rgb_serializer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         rgb_valid,
    input  wire stream_pkg::rgb_beat_t  rgb,
    output logic                        out_valid,
    output demosaic_pkg::pixel_t        rgb_data,
    output stream_pkg::color_t          color,
    output logic                        col_last,
    output logic                        pic_last
);

    typedef enum logic [1:0] {
        BEAT_IDLE,
        BEAT_R,
        BEAT_G,
        BEAT_B
    } beat_t;

    beat_t                  beat_q;
    demosaic_pkg::pixel_t   g_q;
    demosaic_pkg::pixel_t   b_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            color     <= stream_pkg::COLOR_R;
            col_last  <= 1'b0;
            pic_last  <= 1'b0;
            beat_q    <= BEAT_IDLE;
        end else if (rgb_valid) begin
            out_valid <= 1'b1;
            color     <= stream_pkg::COLOR_R;
            col_last  <= rgb.marks.col_last; // held for all three beats
            pic_last  <= rgb.marks.pic_last;
            beat_q    <= BEAT_R;
        end else begin
            case (beat_q)
                BEAT_R: begin
                    color  <= stream_pkg::COLOR_G;
                    beat_q <= BEAT_G;
                end
                BEAT_G: begin
                    color  <= stream_pkg::COLOR_B;
                    beat_q <= BEAT_B;
                end
                BEAT_B: begin
                    out_valid <= 1'b0;
                    color     <= stream_pkg::COLOR_R;
                    col_last  <= 1'b0;
                    pic_last  <= 1'b0;
                    beat_q    <= BEAT_IDLE;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rgb_valid) begin
            rgb_data <= rgb.rgb.r;
            g_q      <= rgb.rgb.g;
            b_q      <= rgb.rgb.b;
        end else if (beat_q == BEAT_R) begin
            rgb_data <= g_q;
        end else if (beat_q == BEAT_G) begin
            rgb_data <= b_q;
        end
    end

    // pixels closer than three cycles would cut a triple short
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        rgb_valid |-> (beat_q == BEAT_IDLE || beat_q == BEAT_B))
        else $error("new triple while R or G beat pending");

endmodule

`default_nettype wire

// File: demosaic_top.sv
`timescale 1ns/10ps
`default_nettype none

module demosaic_top #(
    parameter int COL_HEIGHT = 8
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire                         valid,
    input  wire demosaic_pkg::pixel_t   data_in,
    input  wire                         end_col,
    input  wire                         end_pic,
    output logic                        rgb_valid,
    output demosaic_pkg::pixel_t        rgb_data,
    output stream_pkg::color_t          color,
    output logic                        col_last,
    output logic                        pic_last
);

    logic                       win_valid;
    demosaic_pkg::window_beat_t win;
    logic                       interp_valid;
    stream_pkg::rgb_beat_t      interp_rgb;

    column_buffer #(
        .COL_HEIGHT (COL_HEIGHT)
    ) u_column_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .valid      (valid),
        .data_in    (data_in),
        .end_col    (end_col),
        .end_pic    (end_pic),
        .win_valid  (win_valid),
        .win        (win)
    );

    bayer_interp u_bayer_interp (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_valid  (win_valid),
        .win        (win),
        .rgb_valid  (interp_valid),
        .rgb        (interp_rgb)
    );

    rgb_serializer u_rgb_serializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .rgb_valid  (interp_valid),
        .rgb        (interp_rgb),
        .out_valid  (rgb_valid),
        .rgb_data   (rgb_data),
        .color      (color),
        .col_last   (col_last),
        .pic_last   (pic_last)
    );

endmodule

`default_nettype wire

// File: tb_demosaic.sv
`timescale 1ns/10ps
`default_nettype none

module tb_demosaic;

    localparam int COL_HEIGHT   = 8;
    localparam int DRAIN_LIMIT  = 40;
    localparam int QUIET_CYCLES = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic                   valid;
    demosaic_pkg::pixel_t   data_in;
    logic                   end_col;
    logic                   end_pic;
    logic                   rgb_valid;
    demosaic_pkg::pixel_t   rgb_data;
    stream_pkg::color_t     color;
    logic                   col_last;
    logic                   pic_last;

    stream_pkg::rgb_beat_t  expected [$]; // one entry per E line in file order
    int                     beat_count;
    logic                   started;

    demosaic_top #(
        .COL_HEIGHT (COL_HEIGHT)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .valid      (valid),
        .data_in    (data_in),
        .end_col    (end_col),
        .end_pic    (end_pic),
        .rgb_valid  (rgb_valid),
        .rgb_data   (rgb_data),
        .color      (color),
        .col_last   (col_last),
        .pic_last   (pic_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic halt_on_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int want);
        $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, want);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic stream_pkg::color_t beat_color(input int pos);
        case (pos)
            0:       beat_color = stream_pkg::COLOR_R;
            1:       beat_color = stream_pkg::COLOR_G;
            default: beat_color = stream_pkg::COLOR_B;
        endcase
    endfunction

    function automatic demosaic_pkg::pixel_t beat_value(input stream_pkg::rgb_beat_t t,
                                                        input int pos);
        case (pos)
            0:       beat_value = t.rgb.r;
            1:       beat_value = t.rgb.g;
            default: beat_value = t.rgb.b;
        endcase
    endfunction

    task automatic check_beat();
        int                     idx;
        int                     pos;
        stream_pkg::rgb_beat_t  want;
        idx = beat_count / 3;
        pos = beat_count % 3;
        assert (idx < expected.size())
            else halt_on_error("output beat with no completed window behind it");
        want = expected[idx];
        assert (color == beat_color(pos))
            else report_mismatch("color", int'(color), int'(beat_color(pos)));
        assert (rgb_data == beat_value(want, pos))
            else report_mismatch("rgb_data", int'(rgb_data), int'(beat_value(want, pos)));
        assert (col_last == want.marks.col_last)
            else report_mismatch("col_last", int'(col_last), int'(want.marks.col_last));
        assert (pic_last == want.marks.pic_last)
            else report_mismatch("pic_last", int'(pic_last), int'(want.marks.pic_last));
        beat_count++;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n || !started) begin
            assert (!rgb_valid && !col_last && !pic_last)
                else halt_on_error("output active during reset or before start");
        end else if (rgb_valid) begin
            check_beat();
        end else begin
            assert (beat_count % 3 == 0)
                else halt_on_error("gap inside an R, G, B triple");
            assert (!col_last && !pic_last)
                else halt_on_error("marks high while no beat is valid");
        end
    end

    task automatic pulse_start();
        @(posedge clk);
        start   <= 1'b1;
        started = 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (2) @(posedge clk); // let the registered start reach the FSM
    endtask

    task automatic drive_pixel(input demosaic_pkg::pixel_t d, input logic ec, input logic ep);
        @(posedge clk);
        valid   <= 1'b1;
        data_in <= d;
        end_col <= ec;
        end_pic <= ep;
        @(posedge clk);
        valid   <= 1'b0;
        end_col <= 1'b0;
        end_pic <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_tests();
        int                     fd;
        int                     n;
        int                     v0;
        int                     v1;
        int                     v2;
        int                     v3;
        int                     v4;
        logic [7:0]             tag;
        logic [8*160-1:0]       rest;
        stream_pkg::rgb_beat_t  t;
        fd = $fopen("demosaic_tests.txt", "r");
        assert (fd != 0) else halt_on_error("cannot open demosaic_tests.txt");
        n = $fscanf(fd, " %c", tag);
        while (n == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "I") begin
                n = $fscanf(fd, " %h %h %h", v0, v1, v2);
                assert (n == 3) else halt_on_error("pixel line in test file is malformed");
                drive_pixel(v0[7:0], v1[0], v2[0]);
            end else if (tag == "E") begin
                n = $fscanf(fd, " %h %h %h %h %h", v0, v1, v2, v3, v4);
                assert (n == 5) else halt_on_error("expected line in test file is malformed");
                t.rgb.r          = v0[7:0];
                t.rgb.g          = v1[7:0];
                t.rgb.b          = v2[7:0];
                t.marks.col_last = v3[0];
                t.marks.pic_last = v4[0];
                expected.push_back(t);
            end else begin
                halt_on_error("unknown line type in test file");
            end
            n = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
        assert (expected.size() > 0) else halt_on_error("test file holds no expected triples");
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (beat_count < 3 * expected.size() && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        assert (beat_count == 3 * expected.size())
            else halt_on_error("timed out waiting for the last output beats");
    endtask

    task automatic watch_quiet();
        int cycles;
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin // monitor flags any extra beat
            @(posedge clk);
            cycles++;
        end
    endtask

    initial begin
        beat_count  = 0;
        started     = 1'b0;
        rst_n   <= 1'b0;
        start   <= 1'b0;
        valid   <= 1'b0;
        data_in <= '0;
        end_col <= 1'b0;
        end_pic <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        pulse_start();
        run_tests();
        wait_for_drain();
        watch_quiet();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: demosaic_tests.txt
# I <pixel> <end_col> <end_pic> : one pixel, hex, rows top to bottom, column by column
# E <r> <g> <b> <col_last> <pic_last> : expected triple, follows the pixel completing it
# strip one, column 0
I 0a 0 0
I c9 0 0
I 21 0 0
I b4 0 0
I 34 0 0
I a3 0 0
I 46 0 0
I 8d 0 0
# strip one, column 1
I 5b 0 0
I 14 0 0
I 71 0 0
I 29 0 0
I 82 0 0
I 3e 0 0
I 97 0 0
I 57 0 0
# strip one, column 2, red-first pattern
I 11 0 0
I de 0 0
I 23 0 0
E 17 9c 14 0 0
I c2 0 0
E 22 71 1e 0 0
I 37 0 0
E 2b 9a 29 0 0
I ab 0 0
E 35 82 33 0 0
I 4e 0 0
E 3f 99 3e 0 0
I 96 0 0
E 4a 97 4a 0 0
# strip one, column 3, green-first pattern
I 60 0 0
I 19 0 0
I 76 0 0
E de 18 68 0 0
I 2d 0 0
E d0 23 73 0 0
I 89 0 0
E c2 2c 7c 0 0
I 42 0 0
E b6 37 85 0 0
I 9b 0 0
E ab 41 8f 0 0
I 59 1 0
E a0 4e 99 1 0
# strip two, column 0
I f0 0 0
I 05 0 0
I de 0 0
I 12 0 0
I cd 0 0
I 1f 0 0
I be 0 0
I 2c 0 0
# strip two, column 1
I 0c 0 0
I fa 0 0
I 1b 0 0
I e9 0 0
I 29 0 0
I d8 0 0
I 3a 0 0
I c7 0 0
# strip two, column 2, red-first pattern
I ec 0 0
I 09 0 0
I db 0 0
E e5 0d fa 0 0
I 16 0 0
E dc 1b f1 0 0
I c9 0 0
E d3 1b e9 0 0
I 25 0 0
E cb 29 e0 0 0
I b8 0 0
E c3 29 d8 0 0
I 33 1 1
E bb 3a cf 1 1

// File: sim.f
demosaic_pkg.sv
stream_pkg.sv
column_buffer.sv
bayer_interp.sv
rgb_serializer.sv
demosaic_top.sv
tb_demosaic.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_demosaic
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
